// File: tb.f
core_pkg.sv
instr_fetch.sv
reg_file.sv
instr_decode.sv
alu_execute.sv
retire_writeback.sv
cpu_core.sv
tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_cpu -f tb.f -o tb_cpu_sim > build.log 2>&1 &&
    ./obj_dir/tb_cpu_sim > sim.log 2>&1 ||
    { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Everything OK" sim.log &&
    echo "PASS" ||
    { echo "FAIL"; exit 1; }

// File: tb_cpu.sv
`default_nettype none

module tb_cpu
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [DATA_W-1:0] RESET_PC = 32'h0000_0100;
    localparam int PROG_LEN    = 39;
    localparam int N_RET       = 60;
    // every record may wait on gaps, stalls and a refetch
    localparam int MAX_CYCLES  = N_RET * 4 * 3 + 20;
    localparam int KIND_ALU    = 0;
    localparam int KIND_DEP    = 1;
    localparam int KIND_BRANCH = 2;

    logic              clk;
    logic              reset;
    instr_u            instr;
    logic              instr_valid;
    logic              instr_ready;
    logic              retire_ready;
    logic              retire_valid;
    logic [DATA_W-1:0] fetch_pc;
    retire_t           retire;

    // program and expected retire stream
    logic [DATA_W-1:0] prog [PROG_LEN];
    retire_t           exp_recs [N_RET];
    int                exp_kinds [N_RET];
    int                last_of_kind [3];
    retire_t           exp_rec;
    int                exp_kind;
    // bookkeeping
    int                fails [1:5];
    bit                reported [1:5];
    bit                passed [1:5];
    int                ret_count;
    int                cycles;
    logic              handshake;
    logic              checking;

    cpu_core #(
        .RESET_PC (RESET_PC)
    ) cpu_core_i (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .retire_ready (retire_ready),
        .fetch_pc     (fetch_pc),
        .instr_ready  (instr_ready),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // program build
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] r_word(opcode_e op, int rd, int rs1, int rs2);
        return {op, 5'(rd), 5'(rs1), 5'(rs2), 12'h000};
    endfunction

    function automatic logic [31:0] i_word(opcode_e op, int rd, int rs1, int imm);
        return {op, 5'(rd), 5'(rs1), 17'(imm)};
    endfunction

    task automatic build_program();
        prog[0]  = i_word(OP_ADDI, 1, 0, 5);
        prog[1]  = i_word(OP_ADDI, 2, 0, -3);
        // back to back, forward and write-through
        prog[2]  = r_word(OP_ADD, 3, 1, 2);
        prog[3]  = r_word(OP_SUB, 4, 3, 1);
        prog[4]  = r_word(OP_AND, 5, 1, 2);
        prog[5]  = r_word(OP_OR, 6, 4, 3);
        prog[6]  = r_word(OP_XOR, 7, 6, 1);
        prog[7]  = i_word(OP_ADDI, 8, 7, -100);
        // zero result, z set
        prog[8]  = r_word(OP_SUB, 9, 1, 5);
        prog[9]  = i_word(OP_BEQ, 0, 0, 2);
        prog[10] = i_word(OP_ADDI, 10, 0, 1);
        prog[11] = i_word(OP_ADDI, 10, 0, 2);
        // z still set, falls through
        prog[12] = i_word(OP_BNE, 0, 0, 5);
        prog[13] = i_word(OP_ADDI, 11, 0, 7);
        prog[14] = i_word(OP_BNE, 0, 0, 1);
        prog[15] = i_word(OP_ADDI, 11, 0, 99);
        prog[16] = i_word(OP_BLT, 0, 0, 3);
        prog[17] = r_word(OP_SUB, 12, 0, 11);
        prog[18] = i_word(OP_BLT, 0, 0, 1);
        prog[19] = i_word(OP_ADDI, 12, 0, 0);
        prog[20] = i_word(OP_BGE, 0, 0, 4);
        prog[21] = r_word(OP_ADD, 13, 12, 11);
        prog[22] = i_word(OP_BGE, 0, 0, 1);
        prog[23] = r_word(OP_XOR, 13, 13, 13);
        prog[24] = i_word(OP_JMP, 0, 0, 2);
        prog[25] = i_word(OP_ADDI, 14, 0, 1);
        prog[26] = i_word(OP_ADDI, 14, 0, 2);
        prog[27] = i_word(OP_ADDI, 14, 14, -1);
        prog[28] = r_word(OP_ADD, 15, 14, 14);
        prog[29] = r_word(OP_ADD, 16, 15, 14);
        prog[30] = r_word(OP_AND, 17, 16, 15);
        prog[31] = r_word(OP_OR, 18, 17, 1);
        prog[32] = r_word(OP_XOR, 19, 18, 16);
        // write to r0 retires but leaves r0 at zero
        prog[33] = i_word(OP_ADDI, 0, 1, 9);
        prog[34] = r_word(OP_ADD, 20, 0, 1);
        prog[35] = i_word(OP_ADDI, 21, 20, -65536);
        prog[36] = r_word(OP_SUB, 22, 21, 20);
        prog[37] = i_word(OP_BEQ, 0, 0, 3);
        // spin here for the rest of the run
        prog[38] = i_word(OP_JMP, 0, 0, -1);
    endtask

    ////////////////////////////////////////////////////////////
    // reference interpreter, program order
    ////////////////////////////////////////////////////////////

    task automatic run_reference();
        logic [DATA_W-1:0] regs [32];
        flags_t            fl;
        logic [31:0]       w;
        opcode_e           op;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [DATA_W-1:0] imm;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] res;
        logic              taken;
        retire_t           rec;
        int                idx;
        int                kind;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        fl = '0;
        idx = 0;
        last_of_kind = '{-1, -1, -1};
        for (int n = 0; n < N_RET; n++) begin
            w   = prog[idx];
            op  = opcode_e'(w[31:27]);
            rd  = w[26:22];
            rs1 = w[21:17];
            rs2 = w[16:12];
            imm = {{(DATA_W - IMM_W){w[IMM_W-1]}}, w[IMM_W-1:0]};
            rec = '0;
            rec.pc = RESET_PC + DATA_W'(idx);
            kind = KIND_ALU;
            res = '0;
            if (op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JMP}) begin
                kind = KIND_BRANCH;
                case (op)
                    OP_BEQ:  taken = fl.z;
                    OP_BNE:  taken = !fl.z;
                    OP_BLT:  taken = fl.n;
                    OP_BGE:  taken = !fl.n;
                    default: taken = 1'b1;
                endcase
                idx = taken ? idx + 1 + $signed(imm) : idx + 1;
            end else begin
                b = (op == OP_ADDI) ? imm : regs[rs2];
                case (op)
                    OP_SUB:  res = regs[rs1] - b;
                    OP_AND:  res = regs[rs1] & b;
                    OP_OR:   res = regs[rs1] | b;
                    OP_XOR:  res = regs[rs1] ^ b;
                    default: res = regs[rs1] + b;
                endcase
                // source written by one of the two records before
                for (int k = 1; k <= 2; k++) begin
                    if (n >= k && exp_recs[n-k].wr_en && exp_recs[n-k].rd != '0 &&
                        (exp_recs[n-k].rd == rs1 ||
                         (op != OP_ADDI && exp_recs[n-k].rd == rs2))) begin
                        kind = KIND_DEP;
                    end
                end
                rec.rd    = rd;
                rec.wr_en = 1'b1;
                rec.data  = res;
                fl = '{n: res[DATA_W-1], z: (res == '0)};
                if (rd != '0) begin
                    regs[rd] = res;
                end
                idx++;
            end
            exp_recs[n]  = rec;
            exp_kinds[n] = kind;
            last_of_kind[kind] = n;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus and report helpers
    ////////////////////////////////////////////////////////////

    task automatic drive_inputs();
        int idx;
        idx = int'(fetch_pc - RESET_PC);
        instr_valid  = ($urandom % 5) != 0;
        retire_ready = ($urandom % 4) != 0;
        if (idx >= 0 && idx < PROG_LEN) begin
            instr = prog[idx];
        end else begin
            instr = i_word(OP_NOP, 0, 0, 0);
        end
    endtask

    function automatic string behavior_name(int b);
        case (b)
            1:       return "reset and first pc";
            2:       return "alu results";
            3:       return "dependent operands";
            4:       return "branches and flush";
            default: return "back-pressure and gaps";
        endcase
    endfunction

    task automatic report_behavior(input int b, input bit complete);
        if (!reported[b]) begin
            reported[b] = 1'b1;
            passed[b] = complete && fails[b] == 0;
            $display("behavior %0d, %s: %s (%0d failed checks)", b, behavior_name(b),
                     passed[b] ? "pass" : (complete ? "FAILED" : "not finished"), fails[b]);
        end
    endtask

    task automatic note_finished();
        if (ret_count >= 1) report_behavior(1, 1'b1);
        if (ret_count > last_of_kind[KIND_ALU]) report_behavior(2, 1'b1);
        if (ret_count > last_of_kind[KIND_DEP]) report_behavior(3, 1'b1);
        if (ret_count > last_of_kind[KIND_BRANCH]) report_behavior(4, 1'b1);
    endtask

    // record the DUT should retire next
    always_comb begin
        exp_rec  = '0;
        exp_kind = KIND_ALU;
        if (ret_count < N_RET) begin
            exp_rec  = exp_recs[ret_count];
            exp_kind = exp_kinds[ret_count];
        end
    end

    assign handshake = retire_valid && retire_ready;
    assign checking  = handshake && ret_count < N_RET;

    always @(posedge clk) begin
        if (reset) begin
            ret_count <= 0;
            cycles    <= 0;
        end else begin
            cycles <= cycles + 1;
            if (handshake) begin
                ret_count <= ret_count + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    reset_idle: assert property (@(posedge clk) reset |=> !retire_valid)
        else begin
            fails[1]++;
            $display("ERROR retire_valid got %h expected %h", $sampled(retire_valid), 1'b0);
        end

    first_pc: assert property (@(posedge clk) disable iff (reset)
        checking && ret_count == 0 |-> retire.pc == RESET_PC)
        else begin
            fails[1]++;
            $display("ERROR retire.pc got %h expected %h", $sampled(retire.pc), RESET_PC);
        end

    alu_record: assert property (@(posedge clk) disable iff (reset)
        checking && exp_kind == KIND_ALU |-> retire.rd == exp_rec.rd &&
            retire.wr_en == exp_rec.wr_en && retire.data == exp_rec.data)
        else begin
            fails[2]++;
            $display("ERROR retire got %h expected %h", $sampled(retire), $sampled(exp_rec));
        end

    dep_record: assert property (@(posedge clk) disable iff (reset)
        checking && exp_kind == KIND_DEP |-> retire.rd == exp_rec.rd &&
            retire.wr_en == exp_rec.wr_en && retire.data == exp_rec.data)
        else begin
            fails[3]++;
            $display("ERROR retire got %h expected %h", $sampled(retire), $sampled(exp_rec));
        end

    // branch retires at its own pc and writes nothing
    branch_record: assert property (@(posedge clk) disable iff (reset)
        checking && exp_kind == KIND_BRANCH |-> retire.pc == exp_rec.pc && !retire.wr_en)
        else begin
            fails[4]++;
            $display("ERROR retire got %h expected %h", $sampled(retire), $sampled(exp_rec));
        end

    retire_order: assert property (@(posedge clk) disable iff (reset)
        checking |-> retire.pc == exp_rec.pc)
        else begin
            fails[5]++;
            $display("ERROR retire.pc got %h expected %h",
                     $sampled(retire.pc), $sampled(exp_rec.pc));
        end

    record_held: assert property (@(posedge clk) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire))
        else begin
            fails[5]++;
            $display("a retire record changed or vanished before it was taken");
        end

    // record waiting at the retire port closes the instruction port
    port_closed: assert property (@(posedge clk) disable iff (reset)
        retire_valid && !retire_ready |-> !instr_ready)
        else begin
            fails[5]++;
            $display("ERROR instr_ready got %h expected %h", $sampled(instr_ready), 1'b0);
        end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int n_pass;
        bit timed_out;
        void'($urandom(83));
        reset        = 1'b1;
        instr        = '0;
        instr_valid  = 1'b0;
        retire_ready = 1'b0;
        for (int b = 1; b <= 5; b++) begin
            fails[b]    = 0;
            reported[b] = 1'b0;
            passed[b]   = 1'b0;
        end
        build_program();
        run_reference();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (ret_count < N_RET && cycles < MAX_CYCLES) begin
            drive_inputs();
            @(negedge clk);
            note_finished();
        end
        timed_out = ret_count < N_RET;
        if (timed_out) begin
            $display("timeout: only %0d of %0d records retired in %0d cycles",
                     ret_count, N_RET, cycles);
        end
        n_pass = 0;
        for (int b = 1; b <= 5; b++) begin
            report_behavior(b, !timed_out);
            if (passed[b]) n_pass++;
        end
        $display("tests: %0d passed, %0d failed, %0d records retired",
                 n_pass, 5 - n_pass, ret_count);
        if (n_pass == 5) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu_core.sv
`default_nettype none

module cpu_core
    import core_pkg::*;
#(
    parameter logic [DATA_W-1:0] RESET_PC = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  instr_u            instr,
    input  logic              instr_valid,
    input  logic              retire_ready,
    output logic [DATA_W-1:0] fetch_pc,
    output logic              instr_ready,
    output retire_t           retire,
    output logic              retire_valid
);

    // stage registers
    fetch_t    fe;
    decoded_t  de;
    retire_t   ex;
    logic      ex_valid;
    // control between stages
    redirect_t redirect;
    logic      hold;
    logic      commit;

    ////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////

    instr_fetch #(
        .RESET_PC (RESET_PC)
    ) instr_fetch_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .hold        (hold),
        .redirect    (redirect),
        .fetch_pc    (fetch_pc),
        .instr_ready (instr_ready),
        .fe          (fe)
    );

    ////////////////////////////////////////////////////////////
    // decode, flushed by a taken branch
    ////////////////////////////////////////////////////////////

    instr_decode instr_decode_i (
        .clk    (clk),
        .reset  (reset),
        .fe     (fe),
        .hold   (hold),
        .flush  (redirect.valid),
        .wb     (retire),
        .commit (commit),
        .de     (de)
    );

    // execute
    alu_execute alu_execute_i (
        .clk      (clk),
        .reset    (reset),
        .de       (de),
        .hold     (hold),
        .redirect (redirect),
        .ex       (ex),
        .ex_valid (ex_valid)
    );

    // writeback and retire port
    retire_writeback retire_writeback_i (
        .clk          (clk),
        .reset        (reset),
        .ex           (ex),
        .ex_valid     (ex_valid),
        .retire_ready (retire_ready),
        .retire       (retire),
        .retire_valid (retire_valid),
        .hold         (hold),
        .commit       (commit)
    );

endmodule

`default_nettype wire

// File: retire_writeback.sv
`default_nettype none

module retire_writeback
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  retire_t ex,
    input  logic    ex_valid,
    input  logic    retire_ready,
    output retire_t retire,
    output logic    retire_valid,
    output logic    hold,
    output logic    commit
);

    ////////////////////////////////////////////////////////////
    // retire port
    ////////////////////////////////////////////////////////////

    // execute result goes out as the retire record
    assign retire       = ex;
    assign retire_valid = ex_valid;

    // record waiting, freeze every stage
    assign hold   = ex_valid && !retire_ready;
    // register write once, on the handshake
    assign commit = ex_valid && retire_ready;

    // a record not taken stays put until it is taken
    retire_stable: assert property (
        @(posedge clk) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire)
    );

endmodule

`default_nettype wire

// File: alu_execute.sv
`default_nettype none

module alu_execute
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  decoded_t  de,
    input  logic      hold,
    output redirect_t redirect,
    output retire_t   ex,
    output logic      ex_valid
);

    flags_t            flags;
    logic [DATA_W-1:0] a_op;
    logic [DATA_W-1:0] b_fwd;
    logic [DATA_W-1:0] b_op;
    logic [DATA_W-1:0] result;
    logic              is_alu;
    logic              taken;

    ////////////////////////////////////////////////////////////
    // operand forwarding
    ////////////////////////////////////////////////////////////

    // older instruction still in writeback wins over the
    // value read in decode
    function automatic logic [DATA_W-1:0] forward(
        input logic [REG_ADDR_W-1:0] sel,
        input logic [DATA_W-1:0]     reg_val,
        input retire_t               ahead,
        input logic                  ahead_valid
    );
        if (ahead_valid && ahead.wr_en && ahead.rd != '0 && ahead.rd == sel) begin
            return ahead.data;
        end
        return reg_val;
    endfunction

    assign a_op  = forward(de.rs1, de.a_val, ex, ex_valid);
    assign b_fwd = forward(de.rs2, de.b_val, ex, ex_valid);
    // addi takes the immediate instead
    assign b_op  = de.use_imm ? de.imm_ext : b_fwd;

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////

    always_comb begin
        is_alu = 1'b1;
        result = '0;
        case (de.op)
            OP_ADD, OP_ADDI: result = a_op + b_op;
            OP_SUB:          result = a_op - b_op;
            OP_AND:          result = a_op & b_op;
            OP_OR:           result = a_op | b_op;
            OP_XOR:          result = a_op ^ b_op;
            // branches, jmp and nop leave data at zero
            default:         is_alu = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // branch resolution
    ////////////////////////////////////////////////////////////

    // flags already hold the result of the instruction ahead
    always_comb begin
        case (de.op)
            OP_BEQ:  taken = flags.z;
            OP_BNE:  taken = !flags.z;
            OP_BLT:  taken = flags.n;
            OP_BGE:  taken = !flags.n;
            OP_JMP:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // target is relative to the next word
    assign redirect = '{valid:  de.valid && taken && !hold,
                        target: de.pc + DATA_W'(1) + de.imm_ext};

    ////////////////////////////////////////////////////////////
    // flags and execute/writeback register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            flags    <= '0;
            ex_valid <= 1'b0;
        end else if (!hold) begin
            ex_valid <= de.valid;
            ex       <= '{pc: de.pc, rd: de.rd, wr_en: de.valid && de.wr_en, data: result};
            // alu ops update n and z, branches do not
            if (de.valid && is_alu) begin
                flags <= '{n: result[DATA_W-1], z: result == '0};
            end
        end
    end

    // only a real instruction can redirect
    redirect_from_valid: assert property (
        @(posedge clk) disable iff (reset)
        redirect.valid |-> de.valid
    );

    // the instruction behind a taken branch never reaches execute
    redirect_kills_next: assert property (
        @(posedge clk) disable iff (reset)
        redirect.valid |=> !de.valid
    );

endmodule

`default_nettype wire

// File: instr_decode.sv
`default_nettype none

module instr_decode
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  fetch_t   fe,
    input  logic     hold,
    input  logic     flush,
    input  retire_t  wb,
    input  logic     commit,
    output decoded_t de
);

    instr_u                ins;
    opcode_e               op;
    logic [REG_ADDR_W-1:0] rd_sel;
    logic [REG_ADDR_W-1:0] rs1_sel;
    logic [REG_ADDR_W-1:0] rs2_sel;
    logic [DATA_W-1:0]     rs1_val;
    logic [DATA_W-1:0]     rs2_val;
    logic [DATA_W-1:0]     imm_ext;
    logic                  use_imm;
    logic                  wr_en;

    assign ins = fe.instr;
    // opcode sits in the same bits in both views
    assign op  = ins.r.opcode;

    ////////////////////////////////////////////////////////////
    // field decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_sel  = '0;
        rs1_sel = '0;
        rs2_sel = '0;
        use_imm = 1'b0;
        wr_en   = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                // r view, two register sources
                rd_sel  = ins.r.rd;
                rs1_sel = ins.r.rs1;
                rs2_sel = ins.r.rs2;
                wr_en   = fe.valid;
            end
            OP_ADDI: begin
                // i view, imm replaces rs2
                rd_sel  = ins.i.rd;
                rs1_sel = ins.i.rs1;
                use_imm = 1'b1;
                wr_en   = fe.valid;
            end
            // branches and jmp only need the offset
            // nop and unknown opcodes write nothing
            default: ;
        endcase
    end

    // offset or addend, sign extended to a word
    assign imm_ext = {{(DATA_W-IMM_W){ins.i.imm[IMM_W-1]}}, ins.i.imm};

    reg_file reg_file_i (
        .clk     (clk),
        .reset   (reset),
        .rs1     (rs1_sel),
        .rs2     (rs2_sel),
        .wb      (wb),
        .commit  (commit),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    ////////////////////////////////////////////////////////////
    // decode/execute register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            de.valid <= 1'b0;
            de.wr_en <= 1'b0;
        end else if (!hold) begin
            de <= '{valid: fe.valid, pc: fe.pc, op: op, rd: rd_sel,
                    rs1: rs1_sel, rs2: rs2_sel, a_val: rs1_val,
                    b_val: rs2_val, imm_ext: imm_ext,
                    use_imm: use_imm, wr_en: wr_en};
            // taken branch ahead, kill this one
            if (flush) begin
                de.valid <= 1'b0;
                de.wr_en <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  retire_t               wb,
    input  logic                  commit,
    output logic [DATA_W-1:0]     rs1_val,
    output logic [DATA_W-1:0]     rs2_val
);

    logic [DATA_W-1:0] regs [0:(1 << REG_ADDR_W)-1];

    // r0 is hard zero
    // writeback of this cycle bypasses the array
    function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] sel);
        if (sel == '0) begin
            return '0;
        end
        if (commit && wb.wr_en && wb.rd == sel) begin
            return wb.data;
        end
        return regs[sel];
    endfunction

    always_comb begin
        rs1_val = read_port(rs1);
        rs2_val = read_port(rs2);
    end

    // write only on a retire handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (commit && wb.wr_en && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

`default_nettype wire

// File: instr_fetch.sv
`default_nettype none

module instr_fetch
    import core_pkg::*;
#(
    parameter logic [DATA_W-1:0] RESET_PC = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  instr_u            instr,
    input  logic              instr_valid,
    input  logic              hold,
    input  redirect_t         redirect,
    output logic [DATA_W-1:0] fetch_pc,
    output logic              instr_ready,
    output fetch_t            fe
);

    logic accept;

    ////////////////////////////////////////////////////////////
    // instruction port handshake
    ////////////////////////////////////////////////////////////

    // no new instruction while frozen or while redirecting
    assign instr_ready = !hold && !redirect.valid;
    assign accept      = instr_valid && instr_ready;

    ////////////////////////////////////////////////////////////
    // pc and fetch/decode register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= RESET_PC;
            fe.valid <= 1'b0;
        end else if (redirect.valid) begin
            // taken branch, restart at target
            fetch_pc <= redirect.target;
            // younger instruction in decode is dropped
            fe.valid <= 1'b0;
        end else if (!hold) begin
            // gap on the port becomes a bubble
            fe.valid <= accept;
            if (accept) begin
                // word-addressed, one step per instruction
                fetch_pc <= fetch_pc + DATA_W'(1);
                fe.pc    <= fetch_pc;
                fe.instr <= instr;
            end
        end
    end

    // frozen pipeline keeps the fetch address
    pc_held: assert property (
        @(posedge clk) disable iff (reset)
        hold && !redirect.valid |=> $stable(fetch_pc)
    );

endmodule

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

package core_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // data word, also the word-addressed pc
    localparam int DATA_W     = 32;
    // register selector for 32 registers
    localparam int REG_ADDR_W = 5;
    // i-format immediate, sign extended in decode
    localparam int IMM_W      = 17;

    ////////////////////////////////////////////////////////////
    // instruction encoding
    ////////////////////////////////////////////////////////////

    // 5-bit opcode in the top bits of every instruction
    typedef enum logic [4:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_AND  = 5'd2,
        OP_OR   = 5'd3,
        OP_XOR  = 5'd4,
        OP_ADDI = 5'd5,
        OP_BEQ  = 5'd8,
        OP_BNE  = 5'd9,
        OP_BLT  = 5'd10,
        OP_BGE  = 5'd11,
        OP_JMP  = 5'd12,
        OP_NOP  = 5'd31
    } opcode_e;

    // n in bit 1, z in bit 0
    typedef struct packed {
        logic n;
        logic z;
    } flags_t;

    // register-register view
    typedef struct packed {
        opcode_e                opcode;
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [11:0]            unused;
    } instr_r_t;

    // immediate view, addi and branches
    typedef struct packed {
        opcode_e                opcode;
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [IMM_W-1:0]       imm;
    } instr_i_t;

    // one 32-bit word, two decodings
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    ////////////////////////////////////////////////////////////
    // pipeline registers
    ////////////////////////////////////////////////////////////

    // fetch to decode
    typedef struct packed {
        logic               valid;
        logic [DATA_W-1:0]  pc;
        instr_u             instr;
    } fetch_t;

    // decode to execute
    typedef struct packed {
        logic                   valid;
        logic [DATA_W-1:0]      pc;
        opcode_e                op;
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [DATA_W-1:0]      a_val;
        logic [DATA_W-1:0]      b_val;
        logic [DATA_W-1:0]      imm_ext;
        logic                   use_imm;
        logic                   wr_en;
    } decoded_t;

    // execute to writeback, also the retire record
    typedef struct packed {
        logic [DATA_W-1:0]      pc;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   wr_en;
        logic [DATA_W-1:0]      data;
    } retire_t;

    // taken branch back to fetch
    typedef struct packed {
        logic               valid;
        logic [DATA_W-1:0]  target;
    } redirect_t;

endpackage

`default_nettype wire
